// ==== common/div_pkg.sv ====
// ------------------------------------------------
// Divide unit package
// Data width, operation encoding and instruction tag
// shared by the pipelined divider and its testbench
// ------------------------------------------------
package div_pkg;

    // ------------------------------------------------
    // Widths
    // ------------------------------------------------
    localparam int XLEN               = 64;  // RV64 data width
    localparam int DEF_BITS_PER_STAGE = 2;   // Quotient bits per stage, must divide 32

    typedef logic [XLEN-1:0] xlen_t;

    // ------------------------------------------------
    // Operation encoding
    // ------------------------------------------------
    // Bit 0 marks unsigned, bit 1 remainder and bit 2 the
    // 32-bit word forms, so each property is a single bit
    typedef enum logic [2:0] {
        DIV   = 3'b000,
        DIVU  = 3'b001,
        REM   = 3'b010,
        REMU  = 3'b011,
        DIVW  = 3'b100,
        DIVUW = 3'b101,
        REMW  = 3'b110,
        REMUW = 3'b111
    } div_op_t;

    // Instruction identity carried down the pipeline
    typedef struct packed {
        logic [4:0] rd;       // Destination register
        logic [5:0] rob_idx;  // Reorder buffer slot
    } div_tag_t;

    // ------------------------------------------------
    // Operation properties
    // ------------------------------------------------

    // 32-bit word form
    function automatic logic op_is_w(div_op_t op);
        return op[2];
    endfunction

    // Signed operands
    function automatic logic op_is_signed(div_op_t op);
        return ~op[0];
    endfunction

    // Remainder rather than quotient
    function automatic logic op_is_rem(div_op_t op);
        return op[1];
    endfunction

endpackage

// ==== divider/div_decode.sv ====
// ------------------------------------------------
// Divider operand decode
// Turns the operation and raw operands into unsigned
// magnitudes, sign flags and the aligned array input
// ------------------------------------------------
module div_decode (
    input  div_pkg::div_op_t op_i,
    input  div_pkg::xlen_t   src1_i,           // Dividend
    input  div_pkg::xlen_t   src2_i,           // Divisor
    output div_pkg::xlen_t   dividend_o,       // Original dividend
    output div_pkg::xlen_t   aligned_o,        // Dividend magnitude, aligned for the array
    output div_pkg::xlen_t   divisor_o,        // Divisor magnitude
    output logic             div_zero_o,
    output logic             neg_quotient_o,
    output logic             neg_remainder_o
);

    import div_pkg::*;

    localparam int HALF = XLEN / 2;

    logic  op_w;
    logic  op_signed;
    logic  src1_neg;
    logic  src2_neg;
    xlen_t src1_mag;
    xlen_t src2_mag;

    assign op_w      = op_is_w(op_i);
    assign op_signed = op_is_signed(op_i);

    // Sign bit sits at 31 for word forms
    assign src1_neg = op_signed & (op_w ? src1_i[HALF-1] : src1_i[XLEN-1]);
    assign src2_neg = op_signed & (op_w ? src2_i[HALF-1] : src2_i[XLEN-1]);

    // Low half of the 64-bit negation is also the 32-bit magnitude
    assign src1_mag = src1_neg ? (~src1_i + 1'b1) : src1_i;
    assign src2_mag = src2_neg ? (~src2_i + 1'b1) : src2_i;

    assign dividend_o = src1_i;

    // Word dividend goes to the top so 32 array bits finish it
    assign aligned_o = op_w ? {src1_mag[HALF-1:0], {HALF{1'b0}}} : src1_mag;
    assign divisor_o = op_w ? {{HALF{1'b0}}, src2_mag[HALF-1:0]} : src2_mag;

    assign div_zero_o      = op_w ? ~|src2_i[HALF-1:0] : ~|src2_i;
    assign neg_quotient_o  = src1_neg ^ src2_neg;  // Both already gated by signedness
    assign neg_remainder_o = src1_neg;

endmodule

// ==== divider/div_radix_stage.sv ====
// ------------------------------------------------
// Divider radix stage
// Combinational restoring shift-subtract step that
// retires BITS_PER_STAGE quotient bits
// ------------------------------------------------
module div_radix_stage #(
    parameter int BITS_PER_STAGE = div_pkg::DEF_BITS_PER_STAGE
) (
    input  div_pkg::xlen_t remainder_i,
    input  div_pkg::xlen_t dividend_quotient_i,  // Dividend bits on top, quotient growing below
    input  div_pkg::xlen_t divisor_i,
    output div_pkg::xlen_t remainder_o,
    output div_pkg::xlen_t dividend_quotient_o
);

    import div_pkg::*;

    xlen_t         rem;
    xlen_t         dq;
    logic [XLEN:0] shifted;  // One extra bit, partial remainder can reach 2x divisor
    logic [XLEN:0] diff;
    logic          fits;

    always_comb begin
        rem     = remainder_i;
        dq      = dividend_quotient_i;
        shifted = '0;
        diff    = '0;
        fits    = 1'b0;
        for (int b = 0; b < BITS_PER_STAGE; b++) begin
            shifted = {rem, dq[XLEN-1]};          // Bring down next dividend bit
            diff    = shifted - {1'b0, divisor_i};
            fits    = (shifted >= {1'b0, divisor_i});
            rem     = fits ? diff[XLEN-1:0] : shifted[XLEN-1:0];
            dq      = {dq[XLEN-2:0], fits};       // Quotient bit enters at the bottom
        end
        remainder_o         = rem;
        dividend_quotient_o = dq;
    end

endmodule

// ==== divider/div_array.sv ====
// ------------------------------------------------
// Divider array
// Registered chain of radix stages with the flag and
// tag pipeline, kill flush and the word and 64-bit taps
// ------------------------------------------------
module div_array #(
    parameter int BITS_PER_STAGE = div_pkg::DEF_BITS_PER_STAGE
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              kill_i,            // Flush everything in flight
    input  logic              valid_i,
    input  div_pkg::div_op_t  op_i,
    input  div_pkg::div_tag_t tag_i,
    input  div_pkg::xlen_t    dividend_i,
    input  div_pkg::xlen_t    aligned_i,
    input  div_pkg::xlen_t    divisor_i,
    input  logic              div_zero_i,
    input  logic              neg_quotient_i,
    input  logic              neg_remainder_i,
    // Word tap, halfway down
    output logic              w_valid_o,
    output div_pkg::div_op_t  w_op_o,
    output div_pkg::div_tag_t w_tag_o,
    output div_pkg::xlen_t    w_quotient_o,
    output div_pkg::xlen_t    w_remainder_o,
    output div_pkg::xlen_t    w_dividend_o,
    output logic              w_div_zero_o,
    output logic              w_neg_quotient_o,
    output logic              w_neg_remainder_o,
    // 64-bit tap, end of the chain
    output logic              d_valid_o,
    output div_pkg::div_op_t  d_op_o,
    output div_pkg::div_tag_t d_tag_o,
    output div_pkg::xlen_t    d_quotient_o,
    output div_pkg::xlen_t    d_remainder_o,
    output div_pkg::xlen_t    d_dividend_o,
    output logic              d_div_zero_o,
    output logic              d_neg_quotient_o,
    output logic              d_neg_remainder_o
);

    import div_pkg::*;

    localparam int STAGES = XLEN / BITS_PER_STAGE;
    localparam int W_TAP  = STAGES / 2;

    // State held by one pipeline register
    typedef struct packed {
        logic     valid;
        div_op_t  op;
        div_tag_t tag;
        xlen_t    dividend;   // Original operand for the div-by-zero remainder
        xlen_t    divisor;
        xlen_t    rem;
        xlen_t    dq;
        logic     div_zero;
        logic     neg_quotient;
        logic     neg_remainder;
    } stage_t;

    stage_t stage_q [0:STAGES];
    stage_t stage_d [0:STAGES];
    xlen_t  rem_next [0:STAGES-1];
    xlen_t  dq_next  [0:STAGES-1];

    // ------------------------------------------------
    // Shift-subtract chain
    // ------------------------------------------------
    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        div_radix_stage #(
            .BITS_PER_STAGE (BITS_PER_STAGE)
        ) u_stage (
            .remainder_i         (stage_q[s].rem),
            .dividend_quotient_i (stage_q[s].dq),
            .divisor_i           (stage_q[s].divisor),
            .remainder_o         (rem_next[s]),
            .dividend_quotient_o (dq_next[s])
        );
    end

    always_comb begin
        stage_d[0].valid         = valid_i;
        stage_d[0].op            = op_i;
        stage_d[0].tag           = tag_i;
        stage_d[0].dividend      = dividend_i;
        stage_d[0].divisor       = divisor_i;
        stage_d[0].rem           = '0;               // Partial remainder starts empty
        stage_d[0].dq            = aligned_i;
        stage_d[0].div_zero      = div_zero_i;
        stage_d[0].neg_quotient  = neg_quotient_i;
        stage_d[0].neg_remainder = neg_remainder_i;
        for (int s = 0; s < STAGES; s++) begin
            stage_d[s+1]     = stage_q[s];
            stage_d[s+1].rem = rem_next[s];
            stage_d[s+1].dq  = dq_next[s];
            // Word ops leave at their tap
            if (s == W_TAP) begin
                stage_d[s+1].valid = stage_q[s].valid & ~op_is_w(stage_q[s].op);
            end
        end
    end

    // ------------------------------------------------
    // Pipeline registers
    // ------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int s = 0; s <= STAGES; s++) begin
                stage_q[s] <= '0;
            end
        end else if (kill_i) begin
            for (int s = 0; s <= STAGES; s++) begin
                stage_q[s] <= '0;   // Includes the op arriving this cycle
            end
        end else begin
            for (int s = 0; s <= STAGES; s++) begin
                stage_q[s] <= stage_d[s];
            end
        end
    end

    // ------------------------------------------------
    // Taps
    // ------------------------------------------------
    // Word tap only reports word ops, 64-bit ops pass by mid-flight
    assign w_valid_o         = stage_q[W_TAP].valid & op_is_w(stage_q[W_TAP].op);
    assign w_op_o            = stage_q[W_TAP].op;
    assign w_tag_o           = stage_q[W_TAP].tag;
    assign w_quotient_o      = stage_q[W_TAP].dq;
    assign w_remainder_o     = stage_q[W_TAP].rem;
    assign w_dividend_o      = stage_q[W_TAP].dividend;
    assign w_div_zero_o      = stage_q[W_TAP].div_zero;
    assign w_neg_quotient_o  = stage_q[W_TAP].neg_quotient;
    assign w_neg_remainder_o = stage_q[W_TAP].neg_remainder;

    assign d_valid_o         = stage_q[STAGES].valid;
    assign d_op_o            = stage_q[STAGES].op;
    assign d_tag_o           = stage_q[STAGES].tag;
    assign d_quotient_o      = stage_q[STAGES].dq;
    assign d_remainder_o     = stage_q[STAGES].rem;
    assign d_dividend_o      = stage_q[STAGES].dividend;
    assign d_div_zero_o      = stage_q[STAGES].div_zero;
    assign d_neg_quotient_o  = stage_q[STAGES].neg_quotient;
    assign d_neg_remainder_o = stage_q[STAGES].neg_remainder;

endmodule

// ==== divider/div_result.sv ====
// ------------------------------------------------
// Divider result
// Picks the completing tap, then applies sign fix-up,
// divide-by-zero values and word sign extension
// ------------------------------------------------
module div_result #(
    parameter int BITS_PER_STAGE = div_pkg::DEF_BITS_PER_STAGE
) (
    input  logic              w_valid_i,
    input  div_pkg::div_op_t  w_op_i,
    input  div_pkg::div_tag_t w_tag_i,
    input  div_pkg::xlen_t    w_quotient_i,
    input  div_pkg::xlen_t    w_remainder_i,
    input  div_pkg::xlen_t    w_dividend_i,
    input  logic              w_div_zero_i,
    input  logic              w_neg_quotient_i,
    input  logic              w_neg_remainder_i,
    input  logic              d_valid_i,
    input  div_pkg::div_op_t  d_op_i,
    input  div_pkg::div_tag_t d_tag_i,
    input  div_pkg::xlen_t    d_quotient_i,
    input  div_pkg::xlen_t    d_remainder_i,
    input  div_pkg::xlen_t    d_dividend_i,
    input  logic              d_div_zero_i,
    input  logic              d_neg_quotient_i,
    input  logic              d_neg_remainder_i,
    output logic              valid_o,
    output div_pkg::div_tag_t tag_o,
    output div_pkg::xlen_t    result_o
);

    import div_pkg::*;

    localparam int STAGES = XLEN / BITS_PER_STAGE;
    localparam int W_BITS = (STAGES / 2) * BITS_PER_STAGE;  // Bits retired at the word tap

    logic    sel_w;
    logic    sel_d;
    div_op_t op;
    xlen_t   quotient;
    xlen_t   remainder;
    xlen_t   dividend;
    logic    div_zero;
    logic    neg_quotient;
    logic    neg_remainder;
    xlen_t   quo_fix;
    xlen_t   rem_fix;
    xlen_t   raw;

    // Word tap wins if both ever complete together
    assign sel_w = w_valid_i & op_is_w(w_op_i);
    assign sel_d = d_valid_i & ~op_is_w(d_op_i);

    assign valid_o       = sel_w | sel_d;
    assign tag_o         = sel_w ? w_tag_i           : d_tag_i;
    assign op            = sel_w ? w_op_i            : d_op_i;
    assign quotient      = sel_w ? w_quotient_i      : d_quotient_i;
    assign remainder     = sel_w ? w_remainder_i     : d_remainder_i;
    assign dividend      = sel_w ? w_dividend_i      : d_dividend_i;
    assign div_zero      = sel_w ? w_div_zero_i      : d_div_zero_i;
    assign neg_quotient  = sel_w ? w_neg_quotient_i  : d_neg_quotient_i;
    assign neg_remainder = sel_w ? w_neg_remainder_i : d_neg_remainder_i;

    // ------------------------------------------------
    // Fix-up
    // ------------------------------------------------
    assign quo_fix = div_zero     ? '1 :                        // All ones on x/0
                     neg_quotient ? (~quotient + 1'b1) : quotient;
    assign rem_fix = div_zero      ? dividend :                 // Remainder is the dividend
                     neg_remainder ? (~remainder + 1'b1) : remainder;

    assign raw = op_is_rem(op) ? rem_fix : quo_fix;

    assign result_o = op_is_w(op) ? {{(XLEN-W_BITS){raw[W_BITS-1]}}, raw[W_BITS-1:0]} : raw;

endmodule

// ==== design/div_unit.sv ====
// ------------------------------------------------
// Pipelined divide unit
// Accepts one DIV/REM operation per cycle and returns
// the result with its tag after the array latency
// ------------------------------------------------
module div_unit #(
    parameter int BITS_PER_STAGE = div_pkg::DEF_BITS_PER_STAGE
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              kill_i,
    input  logic              valid_i,
    input  div_pkg::div_op_t  op_i,
    input  div_pkg::div_tag_t tag_i,
    input  div_pkg::xlen_t    src1_i,    // Dividend
    input  div_pkg::xlen_t    src2_i,    // Divisor
    output logic              valid_o,
    output div_pkg::div_tag_t tag_o,
    output div_pkg::xlen_t    result_o
);

    import div_pkg::*;

    // Decode to array
    xlen_t dec_dividend;
    xlen_t dec_aligned;
    xlen_t dec_divisor;
    logic  dec_div_zero;
    logic  dec_neg_quotient;
    logic  dec_neg_remainder;

    // Array taps
    logic     w_valid, d_valid;
    div_op_t  w_op, d_op;
    div_tag_t w_tag, d_tag;
    xlen_t    w_quotient, d_quotient;
    xlen_t    w_remainder, d_remainder;
    xlen_t    w_dividend, d_dividend;
    logic     w_div_zero, d_div_zero;
    logic     w_neg_quotient, d_neg_quotient;
    logic     w_neg_remainder, d_neg_remainder;

    div_decode u_decode (
        .op_i            (op_i),
        .src1_i          (src1_i),
        .src2_i          (src2_i),
        .dividend_o      (dec_dividend),
        .aligned_o       (dec_aligned),
        .divisor_o       (dec_divisor),
        .div_zero_o      (dec_div_zero),
        .neg_quotient_o  (dec_neg_quotient),
        .neg_remainder_o (dec_neg_remainder)
    );

    div_array #(
        .BITS_PER_STAGE (BITS_PER_STAGE)
    ) u_array (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .kill_i            (kill_i),
        .valid_i           (valid_i),
        .op_i              (op_i),
        .tag_i             (tag_i),
        .dividend_i        (dec_dividend),
        .aligned_i         (dec_aligned),
        .divisor_i         (dec_divisor),
        .div_zero_i        (dec_div_zero),
        .neg_quotient_i    (dec_neg_quotient),
        .neg_remainder_i   (dec_neg_remainder),
        .w_valid_o         (w_valid),
        .w_op_o            (w_op),
        .w_tag_o           (w_tag),
        .w_quotient_o      (w_quotient),
        .w_remainder_o     (w_remainder),
        .w_dividend_o      (w_dividend),
        .w_div_zero_o      (w_div_zero),
        .w_neg_quotient_o  (w_neg_quotient),
        .w_neg_remainder_o (w_neg_remainder),
        .d_valid_o         (d_valid),
        .d_op_o            (d_op),
        .d_tag_o           (d_tag),
        .d_quotient_o      (d_quotient),
        .d_remainder_o     (d_remainder),
        .d_dividend_o      (d_dividend),
        .d_div_zero_o      (d_div_zero),
        .d_neg_quotient_o  (d_neg_quotient),
        .d_neg_remainder_o (d_neg_remainder)
    );

    div_result #(
        .BITS_PER_STAGE (BITS_PER_STAGE)
    ) u_result (
        .w_valid_i         (w_valid),
        .w_op_i            (w_op),
        .w_tag_i           (w_tag),
        .w_quotient_i      (w_quotient),
        .w_remainder_i     (w_remainder),
        .w_dividend_i      (w_dividend),
        .w_div_zero_i      (w_div_zero),
        .w_neg_quotient_i  (w_neg_quotient),
        .w_neg_remainder_i (w_neg_remainder),
        .d_valid_i         (d_valid),
        .d_op_i            (d_op),
        .d_tag_i           (d_tag),
        .d_quotient_i      (d_quotient),
        .d_remainder_i     (d_remainder),
        .d_dividend_i      (d_dividend),
        .d_div_zero_i      (d_div_zero),
        .d_neg_quotient_i  (d_neg_quotient),
        .d_neg_remainder_i (d_neg_remainder),
        .valid_o           (valid_o),
        .tag_o             (tag_o),
        .result_o          (result_o)
    );

endmodule

// ==== tests/div_unit_assertions.sv ====
// ------------------------------------------------
// Divide unit checker
// Bound into div_unit, watches reset state, tap
// collisions and the kill flush
// ------------------------------------------------
module div_unit_assertions (
    input logic clk_i,
    input logic rstn_i,
    input logic kill_i,
    input logic out_valid_i,   // valid_o of the unit
    input logic w_valid_i,     // Word tap
    input logic d_valid_i      // 64-bit tap
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;  // Read by the testbench at the end

    // No result leaves while in reset
    reset_quiet: assert property (@(posedge clk_i) !rstn_i |-> !out_valid_i)
        else begin
            fail_count++;
            $error("valid_o high while reset is active");
        end

    // Issue rule keeps the two taps apart
    tap_collision: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                    !(w_valid_i && d_valid_i))
        else begin
            fail_count++;
            $error("word and 64-bit taps valid in the same cycle");
        end

    kill_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                 kill_i |=> !out_valid_i)
        else begin
            fail_count++;
            $error("valid_o high in the cycle after kill_i");
        end

endmodule

bind div_unit div_unit_assertions u_assertions (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .kill_i      (kill_i),
    .out_valid_i (valid_o),
    .w_valid_i   (w_valid),
    .d_valid_i   (d_valid)
);

// ==== tests/div_unit_tb.sv ====
// ------------------------------------------------
// Divide unit testbench
// Directed tests against a RISC-V reference model,
// latency and order checked per result by a monitor
// ------------------------------------------------
module div_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import div_pkg::*;

    localparam int BITS_PER_STAGE = DEF_BITS_PER_STAGE;
    localparam int STAGES         = XLEN / BITS_PER_STAGE;
    localparam int D_LAT          = STAGES + 1;       // 64-bit issue to valid_o
    localparam int W_LAT          = STAGES / 2 + 1;   // Word forms leave halfway
    localparam int CLK_PERIOD     = 4;
    localparam int DRAIN_LIMIT    = 2 * STAGES + 8;
    localparam int OPS_TOTAL      = 2 + 48 + 16 + 10 + 40;
    localparam int WATCHDOG_CYC   = OPS_TOTAL * 40 + 400;
    localparam xlen_t MIN64       = {1'b1, {(XLEN-1){1'b0}}};

    typedef struct packed {
        div_tag_t    tag;
        xlen_t       result;
        logic [31:0] due;      // Monitor cycle of the expected valid_o
    } exp_t;

    logic     clk_i = 1'b0;
    logic     rstn_i;
    logic     kill_i;
    logic     valid_i;
    div_op_t  op_i;
    div_tag_t tag_i;
    xlen_t    src1_i;
    xlen_t    src2_i;
    logic     valid_o;
    div_tag_t tag_o;
    xlen_t    result_o;

    exp_t        exp_q[$];     // Sorted by due cycle
    exp_t        mon_e;
    logic [31:0] cyc = '0;
    logic [10:0] tag_cnt = '0;
    int unsigned mismatch_cnt = 0;
    int unsigned other_cnt = 0;

    div_unit #(
        .BITS_PER_STAGE (BITS_PER_STAGE)
    ) u_div_unit (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .kill_i   (kill_i),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .tag_i    (tag_i),
        .src1_i   (src1_i),
        .src2_i   (src2_i),
        .valid_o  (valid_o),
        .tag_o    (tag_o),
        .result_o (result_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------
    function automatic logic is_word(div_op_t op);
        return op inside {DIVW, DIVUW, REMW, REMUW};
    endfunction

    function automatic xlen_t ref_result(div_op_t op, xlen_t a, xlen_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sq;
        logic signed [31:0] sa_w;
        logic signed [31:0] sb_w;
        logic signed [31:0] sq_w;
        logic [31:0]        w;
        logic               w_zero;
        logic               w_ovf;
        sa     = a;
        sb     = b;
        sa_w   = a[31:0];
        sb_w   = b[31:0];
        w_zero = (b[31:0] == 32'h0);
        w_ovf  = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hFFFF_FFFF);
        case (op)
            DIV: begin
                if (b == '0) return '1;
                if (a == MIN64 && b == '1) return MIN64;
                sq = sa / sb;    // Truncates toward zero
                return sq;
            end
            DIVU:    return (b == '0) ? '1 : a / b;
            REM: begin
                if (b == '0) return a;
                if (a == MIN64 && b == '1) return '0;
                sq = sa % sb;    // Takes the dividend's sign
                return sq;
            end
            REMU:    return (b == '0) ? a : a % b;
            DIVW: begin
                if (w_zero) begin
                    w = 32'hFFFF_FFFF;
                end else if (w_ovf) begin
                    w = a[31:0];
                end else begin
                    sq_w = sa_w / sb_w;
                    w    = sq_w;
                end
            end
            DIVUW:   w = w_zero ? 32'hFFFF_FFFF : a[31:0] / b[31:0];
            REMW: begin
                if (w_zero) begin
                    w = a[31:0];
                end else if (w_ovf) begin
                    w = 32'h0;
                end else begin
                    sq_w = sa_w % sb_w;
                    w    = sq_w;
                end
            end
            default: w = w_zero ? a[31:0] : a[31:0] % b[31:0];
        endcase
        return {{32{w[31]}}, w};   // Word results sign-extend
    endfunction

    // Random operand, magnitude spread over many widths
    function automatic xlen_t rand_operand(logic neg, logic word);
        xlen_t v;
        v = {$urandom, $urandom} >> ($urandom % 63);
        if (word) begin
            v[31] = 1'b0;
            if (neg) v[31:0] = -v[31:0];
            v[63:32] = $urandom;   // Upper garbage must be ignored
        end else begin
            v[63] = 1'b0;
            if (neg) v = -v;
        end
        return v;
    endfunction

    // ------------------------------------------------
    // Compare and scoreboard
    // ------------------------------------------------
    task automatic check_tag(input div_tag_t got, input div_tag_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: tag_o got %h, expected %h", $time, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_result(input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: result_o got %h, expected %h", $time, got, exp);
            mismatch_cnt++;
        end
    endtask

    function automatic logic due_taken(input logic [31:0] due);
        foreach (exp_q[i]) begin
            if (exp_q[i].due == due) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic push_expected(input exp_t e);
        int pos;
        pos = exp_q.size();
        while (pos > 0 && exp_q[pos-1].due > e.due) pos--;
        exp_q.insert(pos, e);
    endtask

    // Sampled on the rising edge, inputs only move on the falling one
    always @(posedge clk_i) begin
        if (rstn_i && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t ns: valid_o with nothing outstanding, tag_o %h",
                         $time, tag_o);
                other_cnt++;
            end else begin
                mon_e = exp_q.pop_front();
                if (mon_e.due != cyc) begin
                    $display("Error at %0t ns: tag %h completed at cycle %0d, due at %0d",
                             $time, mon_e.tag, cyc, mon_e.due);
                    other_cnt++;
                end
                check_tag(tag_o, mon_e.tag);
                check_result(result_o, mon_e.result);
            end
        end
        cyc = cyc + 1;
    end

    // ------------------------------------------------
    // Drive helpers, called on a falling edge
    // ------------------------------------------------
    task automatic issue(input div_op_t op, input xlen_t a, input xlen_t b);
        exp_t e;
        // Word op must not land on a 64-bit result's cycle
        while (is_word(op) && due_taken(cyc + W_LAT)) @(negedge clk_i);
        e.tag    = div_tag_t'(tag_cnt);
        e.result = ref_result(op, a, b);
        e.due    = cyc + (is_word(op) ? W_LAT : D_LAT);
        push_expected(e);
        valid_i = 1'b1;
        op_i    = op;
        tag_i   = e.tag;
        src1_i  = a;
        src2_i  = b;
        tag_cnt = tag_cnt + 1'b1;
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    task automatic wait_drain;
        int unsigned waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Error at %0t ns: %0d results still outstanding after %0d cycles",
                     $time, exp_q.size(), DRAIN_LIMIT);
            other_cnt++;
            exp_q.delete();
        end
    endtask

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic test_reset_idle;
        repeat (STAGES + 2) begin
            @(negedge clk_i);
            if (valid_o) begin
                $display("Error at %0t ns: valid_o rose after reset with no issue", $time);
                other_cnt++;
            end
        end
    endtask

    // Monitor holds each result to its exact due cycle
    task automatic test_single_latency;
        issue(DIV, 64'd1_000_000_007, 64'd13);
        wait_drain();
        issue(DIVW, 64'hFFFF_0000_FFFF_FF9C, 64'd7);
        wait_drain();
    endtask

    task automatic test_signed_unsigned;
        div_op_t op;
        logic    na;
        logic    nb;
        for (int o = 0; o < 8; o++) begin
            op = div_op_t'(o);
            for (int c = 0; c < 6; c++) begin
                na = (c < 4) ? c[0] : $urandom_range(1, 0);
                nb = (c < 4) ? c[1] : $urandom_range(1, 0);
                issue(op, rand_operand(na, is_word(op)), rand_operand(nb, is_word(op)));
            end
        end
        wait_drain();
    endtask

    task automatic test_corner_cases;
        issue(DIV,   64'h0000_0000_0000_1234, '0);
        issue(DIVU,  64'hFFFF_FFFF_FFFF_FFF0, '0);
        issue(REM,   64'h8000_0000_0000_0001, '0);
        issue(REMU,  64'hFFFF_0000_1234_5678, '0);
        issue(DIVW,  64'h1234_5678_0000_0042, 64'hABCD_0000_0000_0000);  // Divisor zero in low half
        issue(DIVUW, 64'h0000_0001_8000_0000, 64'h0000_0001_0000_0000);
        issue(REMW,  64'hFFFF_FFFF_8000_0007, 64'h1111_1111_0000_0000);
        issue(REMUW, 64'h7777_0000_F000_000F, 64'hFFFF_FFFF_0000_0000);
        issue(DIV,   MIN64, '1);
        issue(REM,   MIN64, '1);
        issue(DIVW,  64'h5555_5555_8000_0000, 64'h0000_0000_FFFF_FFFF);
        issue(REMW,  64'hAAAA_AAAA_8000_0000, 64'h1234_5678_FFFF_FFFF);
        issue(DIVUW, 64'hDEAD_BEEF_FFFF_FFFF, 64'h1234_5678_0000_0001);
        issue(REMUW, 64'hDEAD_BEEF_FFFF_FFFF, 64'hCAFE_0000_0000_0010);
        issue(DIV,   '1, '1);
        issue(DIVU,  '1, 64'h2);
        wait_drain();
    endtask

    task automatic test_kill;
        for (int i = 0; i < 6; i++) begin
            issue(i[0] ? DIVW : REM, rand_operand(i[1], i[0]), rand_operand(1'b0, i[0]) | 1);
        end
        repeat (4) @(negedge clk_i);
        kill_i  = 1'b1;
        valid_i = 1'b1;          // Presented with kill, must vanish
        op_i    = DIVU;
        src1_i  = 64'd100;
        src2_i  = 64'd7;
        exp_q.delete();
        @(negedge clk_i);
        kill_i  = 1'b0;
        valid_i = 1'b0;
        repeat (STAGES + 4) @(negedge clk_i);  // Any valid_o here is flagged by the monitor
        issue(DIV, 64'd77, 64'd5);
        issue(REMUW, 64'd77, 64'd5);
        issue(DIVU, 64'hFFFF_FFFF_FFFF_FFFF, 64'd3);
        issue(REMW, 64'hFFFF_FFFF_FFFF_FFB5, 64'd10);
        wait_drain();
    endtask

    task automatic test_mixed_widths;
        div_op_t op;
        for (int i = 0; i < 40; i++) begin
            op = div_op_t'($urandom_range(7, 0));
            issue(op, rand_operand($urandom_range(1, 0), is_word(op)),
                  rand_operand($urandom_range(1, 0), is_word(op)));
            if ($urandom_range(3, 0) == 0) @(negedge clk_i);   // Occasional bubble
        end
        wait_drain();
    endtask

    // ------------------------------------------------
    // Run
    // ------------------------------------------------
    initial begin : watchdog
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Error: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h28b6_abf6));
        rstn_i  = 1'b0;
        kill_i  = 1'b0;
        valid_i = 1'b0;
        op_i    = DIV;
        tag_i   = '0;
        src1_i  = '0;
        src2_i  = '0;
        repeat (3) @(negedge clk_i);
        rstn_i = 1'b1;

        test_reset_idle();
        test_single_latency();
        test_signed_unsigned();
        test_corner_cases();
        test_kill();
        test_mixed_widths();

        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_cnt, other_cnt, u_div_unit.u_assertions.fail_count);
        if (mismatch_cnt == 0 && other_cnt == 0 && u_div_unit.u_assertions.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/div_pkg.sv
divider/div_decode.sv
divider/div_radix_stage.sv
divider/div_array.sv
divider/div_result.sv
design/div_unit.sv
tests/div_unit_assertions.sv
tests/div_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the divide unit testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module div_unit_tb -f build.f -o sim_div_unit \
    && ./obj_dir/sim_div_unit +verilator+error+limit+100000 2>&1 | tee sim.log \
    && ! grep -q "SIMULATION FAILED" sim.log \
    && echo "run.sh: no failure reported in sim.log" \
    || { echo "run.sh: failure, see sim.log"; exit 1; }
